// ==== hw/fb_pkg.sv ====
// Frame buffer widths, span command, pixel pair record and memory request types.
package fb_pkg;

    // Memory word address width.
    localparam int ADDR_W = 29;

    // Memory data width; two 32-bit pixels per word.
    localparam int DATA_W = 64;

    // One horizontal span from the rasterizer.
    typedef struct packed {
        logic [11:0] x;
        logic [11:0] y;
        logic [11:0] length;
        logic [31:0] color;
        logic [31:0] depth;
        logic        depth_write;
    } span_t;

    // One queued pixel pair.
    // A zero address means that port is skipped.
    // Bit 0 of pixel_active is the left pixel, in the low half of the word.
    typedef struct packed {
        logic [ADDR_W-1:0] color_address;
        logic [DATA_W-1:0] color_data;
        logic [ADDR_W-1:0] depth_address;
        logic [DATA_W-1:0] depth_data;
        logic [1:0]        pixel_active;
    } pixel_pair_t;

    // Single-beat memory write request.
    typedef struct packed {
        logic [ADDR_W-1:0]   address;
        logic [DATA_W-1:0]   writedata;
        logic [DATA_W/8-1:0] byteenable;
    } mem_req_t;

endpackage

// ==== hw/span_walker.sv ====
// Span walker that splits span commands into addressed, masked pixel pairs.
`timescale 1ns/10ps

module span_walker import fb_pkg::*; #(
    parameter logic [ADDR_W-1:0] COLOR_BASE = 29'h0001_0000,
    parameter logic [ADDR_W-1:0] DEPTH_BASE = 29'h0004_0000,
    parameter int unsigned STRIDE_WORDS = 320,
    parameter int FIFO_DEPTH = 32,
    parameter int FIFO_DEPTH_LOG2 = 5
) (
    input  logic                       clock,
    input  logic                       reset_n,
    input  logic                       span_start,
    input  span_t                      span,
    output logic                       span_ready,
    input  logic [FIFO_DEPTH_LOG2-1:0] size,
    output logic                       enqueue,
    output pixel_pair_t                pair_in
);

    // Stop short of full; one enqueue is always in flight.
    localparam logic [FIFO_DEPTH_LOG2-1:0] STALL_LEVEL = FIFO_DEPTH_LOG2'(FIFO_DEPTH - 2);

    // Walk state.
    logic        busy;
    logic [11:0] col;
    logic [11:0] remaining;

    // Per-span values, held for the whole walk.
    logic [ADDR_W-1:0] color_row_base;
    logic [ADDR_W-1:0] depth_row_base;
    logic [31:0]       color_value;
    logic [31:0]       depth_value;
    logic              depth_enable;

    // Row offset, only meaningful while span_start is high.
    logic [ADDR_W-1:0] row_offset;

    // Source of the next pair; new span or current walk.
    logic [11:0]       src_col;
    logic [11:0]       src_remaining;
    logic [ADDR_W-1:0] src_color_row;
    logic [ADDR_W-1:0] src_depth_row;
    logic [31:0]       src_color_value;
    logic [31:0]       src_depth_value;
    logic              src_depth_enable;

    logic              left_on;
    logic              right_on;
    logic [11:0]       col_next;
    logic [11:0]       remaining_next;
    logic [ADDR_W-1:0] word_offset;
    logic              stall;
    logic              produce;
    pixel_pair_t       next_pair;

    assign span_ready = !busy;
    assign row_offset = ADDR_W'(span.y) * ADDR_W'(STRIDE_WORDS);
    assign stall = size >= STALL_LEVEL;

    always_comb begin
        src_col          = span_start ? span.x : col;
        src_remaining    = span_start ? span.length : remaining;
        src_color_row    = span_start ? COLOR_BASE + row_offset : color_row_base;
        src_depth_row    = span_start ? DEPTH_BASE + row_offset : depth_row_base;
        src_color_value  = span_start ? span.color : color_value;
        src_depth_value  = span_start ? span.depth : depth_value;
        src_depth_enable = span_start ? span.depth_write : depth_enable;

        // Left pixel is off on an odd start.
        left_on  = !src_col[0];
        // Right pixel is off when the span ends on an even column.
        right_on = src_col[0] || (src_remaining >= 12'd2);

        // Next pair always starts on an even column.
        col_next       = {src_col[11:1] + 11'd1, 1'b0};
        remaining_next = src_remaining - ((left_on && right_on) ? 12'd2 : 12'd1);
        word_offset    = ADDR_W'(src_col[11:1]);

        next_pair.color_address = src_color_row + word_offset;
        next_pair.color_data    = {2{src_color_value}};
        next_pair.depth_address = src_depth_enable ? src_depth_row + word_offset : '0;
        next_pair.depth_data    = {2{src_depth_value}};
        next_pair.pixel_active  = {right_on, left_on};

        produce = (span_start || busy) && (src_remaining != 12'd0) && !stall;
    end

    // Walk control.
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            busy      <= 1'b0;
            enqueue   <= 1'b0;
            col       <= '0;
            remaining <= '0;
        end else begin
            enqueue <= produce;

            // Ready again once the last pair has gone out.
            if (span_start) begin
                busy <= 1'b1;
            end else if (busy && remaining == 12'd0) begin
                busy <= 1'b0;
            end

            if (produce) begin
                col       <= col_next;
                remaining <= remaining_next;
            end else if (span_start) begin
                // Stalled at start; walk begins when the FIFO drains.
                col       <= span.x;
                remaining <= span.length;
            end
        end
    end

    // Span values and the outgoing record.
    always_ff @(posedge clock) begin
        if (span_start) begin
            color_row_base <= COLOR_BASE + row_offset;
            depth_row_base <= DEPTH_BASE + row_offset;
            color_value    <= span.color;
            depth_value    <= span.depth;
            depth_enable   <= span.depth_write;
        end
        if (produce) begin
            pair_in <= next_pair;
        end
    end

    // Source must wait for span_ready.
    a_start_when_ready: assert property (
        @(posedge clock) disable iff (!reset_n) span_start |-> span_ready
    );

endmodule

// ==== hw/pixel_fifo.sv ====
// Synchronous FIFO with registered read data and a type-parameter payload.
`timescale 1ns/10ps

module pixel_fifo #(
    parameter int DEPTH = 32,
    parameter int DEPTH_LOG2 = 5,
    parameter type payload_t = logic [7:0]
) (
    input  logic                  clock,
    input  logic                  reset_n,
    input  logic                  wr,
    input  payload_t              wr_data,
    input  logic                  rd,
    output payload_t              rd_data,
    output logic                  empty,
    output logic [DEPTH_LOG2-1:0] size
);

    localparam logic [DEPTH_LOG2-1:0] LAST = DEPTH_LOG2'(DEPTH - 1);

    // Storage ring.
    payload_t mem [DEPTH];

    logic [DEPTH_LOG2-1:0] wr_ptr;
    logic [DEPTH_LOG2-1:0] rd_ptr;
    // One extra bit so a full ring is distinct from an empty one.
    logic [DEPTH_LOG2:0]   count;
    logic                  full;

    assign empty = count == '0;
    assign full  = count == (DEPTH_LOG2 + 1)'(DEPTH);
    assign size  = count[DEPTH_LOG2-1:0];

    // Pointers and occupancy.
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr) begin
                wr_ptr <= (wr_ptr == LAST) ? '0 : wr_ptr + 1'b1;
            end
            if (rd) begin
                rd_ptr <= (rd_ptr == LAST) ? '0 : rd_ptr + 1'b1;
            end
            if (wr && !rd) begin
                count <= count + 1'b1;
            end else if (rd && !wr) begin
                count <= count - 1'b1;
            end
        end
    end

    // RAM write and registered read; no show-ahead.
    always_ff @(posedge clock) begin
        if (wr) begin
            mem[wr_ptr] <= wr_data;
        end
        if (rd) begin
            rd_data <= mem[rd_ptr];
        end
    end

    a_no_overflow: assert property (@(posedge clock) disable iff (!reset_n) wr |-> !full);
    a_no_underflow: assert property (@(posedge clock) disable iff (!reset_n) rd |-> !empty);

endmodule

// ==== hw/fb_writer.sv ====
// Frame buffer writer that drains pixel pairs into color and depth memory writes.
`timescale 1ns/10ps

module fb_writer import fb_pkg::*; (
    input  logic        clock,
    input  logic        reset_n,
    input  logic        empty,
    input  pixel_pair_t pair,
    output logic        fifo_read,
    output mem_req_t    color_req,
    output logic        color_write,
    input  logic        color_waitrequest,
    output mem_req_t    depth_req,
    output logic        depth_write,
    input  logic        depth_waitrequest
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_READ,
        ST_LOAD,
        ST_WAIT
    } state_t;

    state_t state;

    // Both pixels of a pair share one mask.
    logic [DATA_W/8-1:0] byteenable;
    // A port is finished when idle or completing this cycle.
    logic                color_done;
    logic                depth_done;
    logic                load;

    assign byteenable = {{4{pair.pixel_active[1]}}, {4{pair.pixel_active[0]}}};
    assign color_done = !color_write || !color_waitrequest;
    assign depth_done = !depth_write || !depth_waitrequest;
    assign load       = state == ST_LOAD;

    // Sequencing and write levels.
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            state       <= ST_IDLE;
            fifo_read   <= 1'b0;
            color_write <= 1'b0;
            depth_write <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (!empty) begin
                        fifo_read <= 1'b1;
                        state     <= ST_READ;
                    end
                end
                ST_READ: begin
                    // Record shows up on pair next cycle.
                    fifo_read <= 1'b0;
                    state     <= ST_LOAD;
                end
                ST_LOAD: begin
                    // Zero address skips that port.
                    color_write <= pair.color_address != '0;
                    depth_write <= pair.depth_address != '0;
                    state       <= ST_WAIT;
                end
                ST_WAIT: begin
                    if (color_write && !color_waitrequest) begin
                        color_write <= 1'b0;
                    end
                    if (depth_write && !depth_waitrequest) begin
                        depth_write <= 1'b0;
                    end
                    if (color_done && depth_done) begin
                        state <= ST_IDLE;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // Request payloads, loaded together.
    always_ff @(posedge clock) begin
        if (load) begin
            color_req.address    <= pair.color_address;
            color_req.writedata  <= pair.color_data;
            color_req.byteenable <= byteenable;
            depth_req.address    <= pair.depth_address;
            depth_req.writedata  <= pair.depth_data;
            depth_req.byteenable <= byteenable;
        end
    end

    // Held requests must not move under waitrequest.
    a_color_stable: assert property (
        @(posedge clock) disable iff (!reset_n)
        color_write && color_waitrequest |=> color_write && $stable(color_req)
    );
    a_depth_stable: assert property (
        @(posedge clock) disable iff (!reset_n)
        depth_write && depth_waitrequest |=> depth_write && $stable(depth_req)
    );

endmodule

// ==== hw/fb_write_path.sv ====
// Pixel write-back path top level with walker, pair FIFO and frame buffer writer.
`timescale 1ns/10ps

module fb_write_path import fb_pkg::*; #(
    parameter int FIFO_DEPTH = 32,
    parameter int FIFO_DEPTH_LOG2 = 5,
    parameter logic [ADDR_W-1:0] COLOR_BASE = 29'h0001_0000,
    parameter logic [ADDR_W-1:0] DEPTH_BASE = 29'h0004_0000,
    parameter int unsigned STRIDE_WORDS = 320
) (
    input  logic     clock,
    input  logic     reset_n,
    input  logic     span_start,
    input  span_t    span,
    output logic     span_ready,
    output mem_req_t color_req,
    output logic     color_write,
    input  logic     color_waitrequest,
    output mem_req_t depth_req,
    output logic     depth_write,
    input  logic     depth_waitrequest
);

    // Walker to FIFO.
    logic                       enqueue;
    pixel_pair_t                pair_in;
    logic [FIFO_DEPTH_LOG2-1:0] size;

    // FIFO to writer.
    logic                       fifo_read;
    logic                       empty;
    pixel_pair_t                pair_out;

    span_walker #(
        .COLOR_BASE     (COLOR_BASE),
        .DEPTH_BASE     (DEPTH_BASE),
        .STRIDE_WORDS   (STRIDE_WORDS),
        .FIFO_DEPTH     (FIFO_DEPTH),
        .FIFO_DEPTH_LOG2(FIFO_DEPTH_LOG2)
    ) i_span_walker (
        .clock     (clock),
        .reset_n   (reset_n),
        .span_start(span_start),
        .span      (span),
        .span_ready(span_ready),
        .size      (size),
        .enqueue   (enqueue),
        .pair_in   (pair_in)
    );

    pixel_fifo #(
        .DEPTH     (FIFO_DEPTH),
        .DEPTH_LOG2(FIFO_DEPTH_LOG2),
        .payload_t (pixel_pair_t)
    ) i_pixel_fifo (
        .clock  (clock),
        .reset_n(reset_n),
        .wr     (enqueue),
        .wr_data(pair_in),
        .rd     (fifo_read),
        .rd_data(pair_out),
        .empty  (empty),
        .size   (size)
    );

    fb_writer i_fb_writer (
        .clock            (clock),
        .reset_n          (reset_n),
        .empty            (empty),
        .pair             (pair_out),
        .fifo_read        (fifo_read),
        .color_req        (color_req),
        .color_write      (color_write),
        .color_waitrequest(color_waitrequest),
        .depth_req        (depth_req),
        .depth_write      (depth_write),
        .depth_waitrequest(depth_waitrequest)
    );

endmodule

// ==== tests/tb_clock.sv ====
// Testbench clock and reset generator.
`timescale 1ns/10ps

module tb_clock #(
    parameter int PERIOD_NS = 10,
    parameter int RESET_CYCLES = 2
) (
    output logic clock,
    output logic reset_n
);

    // Free-running clock.
    initial begin
        clock = 1'b0;
        forever #(PERIOD_NS / 2) clock = ~clock;
    end

    // Reset held low for a few edges, released on a rising edge.
    initial begin
        reset_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clock);
        reset_n <= 1'b1;
    end

endmodule

// ==== tests/fb_write_checker.sv ====
// Memory-side checker that builds expected writes per span and compares completed transfers.
`timescale 1ns/10ps

module fb_write_checker import fb_pkg::*; #(
    parameter logic [ADDR_W-1:0] COLOR_BASE = 29'h0001_0000,
    parameter logic [ADDR_W-1:0] DEPTH_BASE = 29'h0004_0000,
    parameter int unsigned STRIDE_WORDS = 320
) (
    input  logic     clock,
    input  logic     span_load,
    input  span_t    span,
    input  logic     check_idle,
    input  logic     span_ready,
    input  mem_req_t color_req,
    input  logic     color_write,
    input  logic     color_waitrequest,
    input  mem_req_t depth_req,
    input  logic     depth_write,
    input  logic     depth_waitrequest,
    output int       color_seen,
    output int       depth_seen,
    output int       error_count
);

    // Expected writes, oldest first.
    mem_req_t color_q [$];
    mem_req_t depth_q [$];

    // One expected request for the word at column pair w.
    function automatic mem_req_t expected_req(input logic [ADDR_W-1:0] base, input span_t s,
                                              input int w, input logic [1:0] active,
                                              input logic [31:0] value);
        mem_req_t r;
        r.address    = base + ADDR_W'(s.y) * ADDR_W'(STRIDE_WORDS) + ADDR_W'(w);
        r.writedata  = {2{value}};
        r.byteenable = {{4{active[1]}}, {4{active[0]}}};
        return r;
    endfunction

    // Expand a span into its word writes.
    task automatic push_span(input span_t s);
        int         end_col;
        int         first_w;
        int         last_w;
        logic [1:0] active;
        if (s.length != 12'd0) begin
            end_col = int'(s.x) + int'(s.length) - 1;
            first_w = int'(s.x) / 2;
            last_w  = end_col / 2;
            for (int w = first_w; w <= last_w; w++) begin
                active = 2'b11;
                // Odd start drops the left pixel.
                if (w == first_w && s.x[0]) begin
                    active[0] = 1'b0;
                end
                // Even end drops the right pixel.
                if (w == last_w && !end_col[0]) begin
                    active[1] = 1'b0;
                end
                color_q.push_back(expected_req(COLOR_BASE, s, w, active, s.color));
                if (s.depth_write) begin
                    depth_q.push_back(expected_req(DEPTH_BASE, s, w, active, s.depth));
                end
            end
        end
    endtask

    task automatic compare_req(input string name, input mem_req_t got, input mem_req_t exp);
        if (got.address !== exp.address) begin
            $display("FAILED %s.address: got %h expected %h", name, got.address, exp.address);
            error_count++;
        end
        if (got.writedata !== exp.writedata) begin
            $display("FAILED %s.writedata: got %h expected %h",
                     name, got.writedata, exp.writedata);
            error_count++;
        end
        if (got.byteenable !== exp.byteenable) begin
            $display("FAILED %s.byteenable: got %h expected %h",
                     name, got.byteenable, exp.byteenable);
            error_count++;
        end
    endtask

    always @(posedge clock) begin
        if (span_load) begin
            push_span(span);
        end

        // Quiet state after reset.
        if (check_idle) begin
            if (span_ready !== 1'b1) begin
                $display("FAILED span_ready: got %h expected %h", span_ready, 1'b1);
                error_count++;
            end
            if (color_write !== 1'b0) begin
                $display("FAILED color_write: got %h expected %h", color_write, 1'b0);
                error_count++;
            end
            if (depth_write !== 1'b0) begin
                $display("FAILED depth_write: got %h expected %h", depth_write, 1'b0);
                error_count++;
            end
        end

        // Transfer ends on write high with waitrequest low.
        if (color_write && !color_waitrequest) begin
            if (color_q.size() == 0) begin
                $display("Unexpected color write to address %h", color_req.address);
                error_count++;
            end else begin
                compare_req("color_req", color_req, color_q.pop_front());
            end
            color_seen++;
        end
        if (depth_write && !depth_waitrequest) begin
            if (depth_q.size() == 0) begin
                $display("Unexpected depth write to address %h", depth_req.address);
                error_count++;
            end else begin
                compare_req("depth_req", depth_req, depth_q.pop_front());
            end
            depth_seen++;
        end
    end

endmodule

// ==== tests/fb_write_path_tb.sv ====
// Testbench top with span table, random waitrequest, stimulus loop and watchdog.
`timescale 1ns/10ps

module fb_write_path_tb import fb_pkg::*; ();

    localparam logic [ADDR_W-1:0] COLOR_BASE = 29'h0001_0000;
    localparam logic [ADDR_W-1:0] DEPTH_BASE = 29'h0004_0000;
    localparam int unsigned STRIDE_WORDS = 320;
    localparam int NUM_TESTS = 5;

    // One table row: span, expected write counts, waitrequest load.
    typedef struct {
        string name;
        span_t span;
        int    color_writes;
        int    depth_writes;
        bit    heavy;
    } test_t;

    test_t tests [NUM_TESTS];

    logic     clock;
    logic     reset_n;
    logic     span_start;
    span_t    span;
    logic     span_ready;
    mem_req_t color_req;
    logic     color_write;
    logic     color_waitrequest = 1'b0;
    mem_req_t depth_req;
    logic     depth_write;
    logic     depth_waitrequest = 1'b0;

    logic        span_load;
    logic        check_idle;
    logic        heavy;
    int          color_seen;
    int          depth_seen;
    int          error_count;
    int          limit_cycles;
    int          current_test;
    int          pass_count;
    int          fail_count;
    logic [31:0] lfsr_state = 32'h4f58;
    logic        bit_a;
    logic        bit_b;

    tb_clock #(.PERIOD_NS(10), .RESET_CYCLES(2)) i_tb_clock (
        .clock  (clock),
        .reset_n(reset_n)
    );

    fb_write_path #(
        .FIFO_DEPTH     (32),
        .FIFO_DEPTH_LOG2(5),
        .COLOR_BASE     (COLOR_BASE),
        .DEPTH_BASE     (DEPTH_BASE),
        .STRIDE_WORDS   (STRIDE_WORDS)
    ) i_fb_write_path (
        .clock            (clock),
        .reset_n          (reset_n),
        .span_start       (span_start),
        .span             (span),
        .span_ready       (span_ready),
        .color_req        (color_req),
        .color_write      (color_write),
        .color_waitrequest(color_waitrequest),
        .depth_req        (depth_req),
        .depth_write      (depth_write),
        .depth_waitrequest(depth_waitrequest)
    );

    fb_write_checker #(
        .COLOR_BASE  (COLOR_BASE),
        .DEPTH_BASE  (DEPTH_BASE),
        .STRIDE_WORDS(STRIDE_WORDS)
    ) i_fb_write_checker (
        .clock            (clock),
        .span_load        (span_load),
        .span             (span),
        .check_idle       (check_idle),
        .span_ready       (span_ready),
        .color_req        (color_req),
        .color_write      (color_write),
        .color_waitrequest(color_waitrequest),
        .depth_req        (depth_req),
        .depth_write      (depth_write),
        .depth_waitrequest(depth_waitrequest),
        .color_seen       (color_seen),
        .depth_seen       (depth_seen),
        .error_count      (error_count)
    );

    // Fibonacci LFSR, taps 32 22 2 1.
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_random_bit(output logic b);
        lfsr_state = lfsr_step(lfsr_state);
        b = lfsr_state[0];
    endtask

    function automatic span_t make_span(input logic [11:0] x, input logic [11:0] y,
                                        input logic [11:0] length, input logic [31:0] color,
                                        input logic [31:0] depth, input logic depth_write);
        span_t s;
        s.x           = x;
        s.y           = y;
        s.length      = length;
        s.color       = color;
        s.depth       = depth;
        s.depth_write = depth_write;
        return s;
    endfunction

    task automatic build_table();
        tests[0] = '{"aligned even span",
                     make_span(12'd10, 12'd3, 12'd16, 32'h1122_3344, 32'h0000_8000, 1'b1),
                     8, 8, 1'b0};
        tests[1] = '{"odd start, even end",
                     make_span(12'd5, 12'd7, 12'd10, 32'hcafe_0001, 32'h0000_1234, 1'b1),
                     6, 6, 1'b0};
        tests[2] = '{"no depth write",
                     make_span(12'd0, 12'd1, 12'd9, 32'h00ff_00ff, 32'hdead_beef, 1'b0),
                     5, 0, 1'b0};
        tests[3] = '{"long span, heavy waitrequest",
                     make_span(12'd40, 12'd20, 12'd200, 32'h7777_aaaa, 32'h0abc_def0, 1'b1),
                     100, 100, 1'b1};
        tests[4] = '{"zero length",
                     make_span(12'd3, 12'd9, 12'd0, 32'h5555_5555, 32'h6666_6666, 1'b1),
                     0, 0, 1'b0};
    endtask

    function automatic int total_pixels();
        int sum;
        sum = 0;
        for (int i = 0; i < NUM_TESTS; i++) begin
            sum += int'(tests[i].span.length);
        end
        return sum;
    endfunction

    task automatic report_test(input int number, input string name, input int errors);
        if (errors == 0) begin
            $display("Test %0d %s: passed", number, name);
            pass_count++;
        end else begin
            $display("Test %0d %s: failed with %0d errors", number, name, errors);
            fail_count++;
        end
    endtask

    // Random waitrequest; heavy mode holds it high three cycles in four.
    always @(posedge clock) begin
        take_random_bit(bit_a);
        if (heavy) begin
            take_random_bit(bit_b);
            color_waitrequest <= !(bit_a && bit_b);
        end else begin
            color_waitrequest <= bit_a;
        end
        take_random_bit(bit_a);
        if (heavy) begin
            take_random_bit(bit_b);
            depth_waitrequest <= !(bit_a && bit_b);
        end else begin
            depth_waitrequest <= bit_a;
        end
    end

    // Watchdog scaled to the table.
    initial begin
        wait (limit_cycles > 0);
        repeat (limit_cycles) @(posedge clock);
        $display("Timeout: test %0d did not finish within %0d cycles", current_test,
                 limit_cycles);
        $display("Simulation finished: FAIL");
        $finish;
    end

    initial begin
        int errors_before;
        int color_target;
        int depth_target;
        int ready_wait;
        int stall_errors;
        span_start   = 1'b0;
        span         = '0;
        span_load    = 1'b0;
        check_idle   = 1'b0;
        heavy        = 1'b0;
        pass_count   = 0;
        fail_count   = 0;
        current_test = 1;
        build_table();
        limit_cycles = total_pixels() * 40 + 1000;

        wait (reset_n);
        @(posedge clock);

        // Idle outputs before any span.
        errors_before = error_count;
        check_idle <= 1'b1;
        @(posedge clock);
        check_idle <= 1'b0;
        @(negedge clock);
        report_test(1, "reset state", error_count - errors_before);

        for (int i = 0; i < NUM_TESTS; i++) begin
            current_test  = i + 2;
            errors_before = error_count;
            color_target  = color_seen + tests[i].color_writes;
            depth_target  = depth_seen + tests[i].depth_writes;
            while (!span_ready) @(negedge clock);
            @(posedge clock);
            span_start <= 1'b1;
            span_load  <= 1'b1;
            span       <= tests[i].span;
            heavy      <= tests[i].heavy;
            @(posedge clock);
            span_start <= 1'b0;
            span_load  <= 1'b0;
            // Done once all writes are in and the walker is free again.
            ready_wait   = 0;
            stall_errors = 0;
            @(negedge clock);
            while (!(color_seen == color_target && depth_seen == depth_target && span_ready)) begin
                if (!span_ready) begin
                    ready_wait++;
                end
                @(negedge clock);
            end
            // Unstalled walker is busy one cycle per pair.
            if (tests[i].heavy && ready_wait <= tests[i].color_writes) begin
                $display("Walker was never held back by a full FIFO in test %0d", current_test);
                stall_errors = 1;
            end
            report_test(current_test, tests[i].name, error_count - errors_before + stall_errors);
        end

        // Quiet window to catch stray writes.
        repeat (20) @(negedge clock);
        if (error_count != 0 && fail_count == 0) begin
            fail_count++;
        end

        $display("Tests passed: %0d, failed: %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// ==== src.f ====
hw/fb_pkg.sv
hw/span_walker.sv
hw/pixel_fifo.sv
hw/fb_writer.sv
hw/fb_write_path.sv
tests/tb_clock.sv
tests/fb_write_checker.sv
tests/fb_write_path_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the frame buffer write path testbench with Verilator.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module fb_write_path_tb \
    -f src.f \
    -o fb_write_path_sim

./obj_dir/fb_write_path_sim > sim.log 2>&1 || true
cat sim.log

# The log decides the result.
if grep -q "Simulation finished: FAIL" sim.log; then
    exit 1
fi
if ! grep -q "Simulation finished: PASS" sim.log; then
    echo "Simulation ended without a result line"
    exit 1
fi
exit 0
